/* c16_bus_pkg.sv */
package c16_bus_pkg;

	////////////////////
	// CPU bus types

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Address inside one 16 KB ROM image
	typedef logic [13:0] rom_addr_t;

	////////////////////
	// Plus/4 banking

	typedef logic [1:0] bank_t;

	// BASIC low, kernal high
	localparam bank_t BANK_SYS  = 2'd0;
	localparam bank_t BANK_CART = 2'd1;
	localparam bank_t BANK_FUNC = 2'd2;

	// Upper address bits of the FDD0-FDDF banking register
	localparam logic [11:0] BANK_REG_PAGE = 12'hFDD;

	// Page always served by the kernal
	localparam logic [7:0] KERNAL_PAGE = 8'hFC;

	// Deselected images float high on the wired-AND bus
	localparam cpu_data_t BUS_IDLE = 8'hFF;

	////////////////////
	// Read bus image positions

	localparam int NUM_IMG     = 6;
	localparam int IMG_KERNAL  = 0;
	localparam int IMG_BASIC   = 1;
	localparam int IMG_FUNC_LO = 2;
	localparam int IMG_FUNC_HI = 3;
	localparam int IMG_CART_LO = 4;
	localparam int IMG_CART_HI = 5;

endpackage

/* c16_load_pkg.sv */
package c16_load_pkg;

	////////////////////
	// Host download

	typedef logic [24:0] load_addr_t;

	localparam logic [7:0] IDX_PRG = 8'h01;
	localparam logic [7:0] IDX_ROM = 8'h03;
	localparam logic [7:0] IDX_CRT = 8'h81;

	// 16 KB slot number, download address bits 24..14
	typedef logic [10:0] slot_t;

	// Slots under IDX_ROM
	localparam slot_t SLOT_KERNAL  = 11'd1;
	localparam slot_t SLOT_BASIC   = 11'd2;
	localparam slot_t SLOT_FUNC_LO = 11'd3;
	localparam slot_t SLOT_FUNC_HI = 11'd4;

	// Slots under IDX_CRT
	localparam slot_t SLOT_CART_LO = 11'd0;
	localparam slot_t SLOT_CART_HI = 11'd1;

	////////////////////
	// BASIC pointers patched after a PRG load
	// Alternating low and high byte of the program end address

	localparam logic [15:0] PRG_PTRS [0:7] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h009D, 16'h009E
	};

endpackage

/* cpu_bus_if.sv */
`timescale 1ns/1ps

interface cpu_bus_if ();
	import c16_bus_pkg::*;

	cpu_addr_t addr;
	cpu_data_t wdata;

	// High for a read cycle
	logic rnw;

	// Chip selects, all active low
	logic cs_ram_n;
	logic cs0_n;
	logic cs1_n;
	logic cs_io_n;

	modport sink (
		input addr,
		input wdata,
		input rnw,
		input cs_ram_n,
		input cs0_n,
		input cs1_n,
		input cs_io_n
	);

endinterface

/* load_bus_if.sv */
`timescale 1ns/1ps

interface load_bus_if ();
	import c16_bus_pkg::*;
	import c16_load_pkg::*;

	// High for the whole file
	logic       download;
	logic [7:0] index;

	// One-cycle strobe, addr and data valid with it
	logic       wr;
	load_addr_t addr;
	cpu_data_t  data;

	modport sink (
		input download,
		input index,
		input wr,
		input addr,
		input data
	);

endinterface

/* prg_loader.sv */
`timescale 1ns/1ps

module prg_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	load_bus_if.sink               ld,
	output c16_bus_pkg::cpu_addr_t dl_addr_o,
	output c16_bus_pkg::cpu_data_t dl_data_o,
	output logic                   dl_wr_o
);
	import c16_bus_pkg::*;
	import c16_load_pkg::*;

	logic       is_prg;
	logic       prg_wr;
	logic       hdr_byte;
	logic       dl_prev;
	logic       dl_end;
	logic [3:0] patch_cnt;
	logic [2:0] ptr_idx;

	// Running RAM address, holds the end address once the file is done
	cpu_addr_t  run_addr;

	assign is_prg   = (ld.index == IDX_PRG);
	assign prg_wr   = ld.download & is_prg & ld.wr;
	assign hdr_byte = (ld.addr[24:1] == '0);
	assign dl_end   = dl_prev & ~ld.download & is_prg;
	assign ptr_idx  = patch_cnt[3:1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev <= 1'b0;
		end else begin
			dl_prev <= ld.download;
		end
	end

	////////////////////
	// Pointer patch sequencer
	// Odd counts write one pointer, the count wraps to idle after 15

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			patch_cnt <= '0;
		end else if (ld.download && is_prg) begin
			patch_cnt <= '0;
		end else if (dl_end) begin
			patch_cnt <= 4'd1;
		end else if (patch_cnt != '0) begin
			patch_cnt <= patch_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wr_o <= 1'b0;
		end else begin
			dl_wr_o <= (prg_wr & ~hdr_byte) | patch_cnt[0];
		end
	end

	////////////////////
	// Address and data toward the RAM loader port

	always_ff @(posedge clk_sys) begin
		if (prg_wr) begin
			// First two bytes carry the load address
			if (ld.addr == '0) begin
				run_addr[7:0] <= ld.data;
			end else if (ld.addr == load_addr_t'(1)) begin
				run_addr[15:8] <= ld.data;
			end else begin
				dl_addr_o <= run_addr;
				dl_data_o <= ld.data;
				run_addr  <= run_addr + 16'd1;
			end
		end else if (patch_cnt[0]) begin
			dl_addr_o <= PRG_PTRS[ptr_idx];
			dl_data_o <= patch_cnt[1] ? run_addr[15:8] : run_addr[7:0];
		end
	end

endmodule

/* main_ram.sv */
`timescale 1ns/1ps

module main_ram #(
	parameter int RAM_AW = 16
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	cpu_bus_if.sink                cpu,
	input  c16_bus_pkg::cpu_addr_t dl_addr_i,
	input  c16_bus_pkg::cpu_data_t dl_data_i,
	input  logic                   dl_wr_i,
	output c16_bus_pkg::cpu_data_t ram_rdata_o
);
	import c16_bus_pkg::*;

	cpu_data_t mem [2**RAM_AW];

	logic cs_prev;
	logic cpu_we;

	////////////////////
	// CPU write strobe from the falling edge of cs_ram_n

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_prev <= 1'b1;
			cpu_we  <= 1'b0;
		end else begin
			cs_prev <= cpu.cs_ram_n;
			cpu_we  <= cs_prev & ~cpu.cs_ram_n & ~cpu.rnw;
		end
	end

	////////////////////
	// Dual-port array

	always_ff @(posedge clk_sys) begin
		if (cpu_we) begin
			mem[cpu.addr[RAM_AW-1:0]] <= cpu.wdata;
		end
		// Loader port wins a same-cycle collision
		if (dl_wr_i) begin
			mem[dl_addr_i[RAM_AW-1:0]] <= dl_data_i;
		end

		if (!cpu.cs_ram_n) begin
			ram_rdata_o <= mem[cpu.addr[RAM_AW-1:0]];
		end else begin
			ram_rdata_o <= BUS_IDLE;
		end
	end

endmodule

/* rom_image.sv */
`timescale 1ns/1ps

module rom_image #(
	parameter int ROM_AW = 14
) (
	input  logic                   clk_sys,
	input  logic                   wr_i,
	input  c16_bus_pkg::rom_addr_t wr_addr_i,
	input  c16_bus_pkg::cpu_data_t wr_data_i,
	input  c16_bus_pkg::rom_addr_t rd_addr_i,
	input  logic                   sel_i,
	output c16_bus_pkg::cpu_data_t rdata_o
);
	import c16_bus_pkg::*;

	// Filled by the host at run time
	cpu_data_t mem [2**ROM_AW];

	always_ff @(posedge clk_sys) begin
		if (wr_i) begin
			mem[wr_addr_i[ROM_AW-1:0]] <= wr_data_i;
		end
	end

	// Deselected image drives the idle level on the read bus
	always_ff @(posedge clk_sys) begin
		if (sel_i) begin
			rdata_o <= mem[rd_addr_i[ROM_AW-1:0]];
		end else begin
			rdata_o <= BUS_IDLE;
		end
	end

endmodule

/* mem_map.sv */
`timescale 1ns/1ps

module mem_map (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    model_i,
	load_bus_if.sink                                ld,
	cpu_bus_if.sink                                 cpu,
	output logic [c16_bus_pkg::NUM_IMG-1:0]         rom_wr_o,
	output logic [c16_bus_pkg::NUM_IMG-1:0]         rom_sel_o,
	input  c16_bus_pkg::cpu_data_t                  ram_rdata_i,
	input  c16_bus_pkg::cpu_data_t                  rom_rdata_i [c16_bus_pkg::NUM_IMG],
	output c16_bus_pkg::cpu_data_t                  cpu_rdata_o
);
	import c16_bus_pkg::*;
	import c16_load_pkg::*;

	logic  plus4;
	logic  cart_lo_ok;
	logic  cart_hi_ok;
	logic  is_rom;
	logic  is_crt;
	logic  cart_hold;
	logic  io_prev;
	logic  bank_wr;
	logic  kern;
	slot_t slot;
	bank_t bank_lo;
	bank_t bank_hi;

	assign slot   = ld.addr[24:14];
	assign is_rom = (ld.index == IDX_ROM);
	assign is_crt = (ld.index == IDX_CRT);

	////////////////////
	// ROM load routing

	assign rom_wr_o[IMG_KERNAL]  = ld.wr & is_rom & (slot == SLOT_KERNAL);
	assign rom_wr_o[IMG_BASIC]   = ld.wr & is_rom & (slot == SLOT_BASIC);
	assign rom_wr_o[IMG_FUNC_LO] = ld.wr & is_rom & (slot == SLOT_FUNC_LO);
	assign rom_wr_o[IMG_FUNC_HI] = ld.wr & is_rom & (slot == SLOT_FUNC_HI);
	assign rom_wr_o[IMG_CART_LO] = ld.wr & is_crt & (slot == SLOT_CART_LO);
	assign rom_wr_o[IMG_CART_HI] = ld.wr & is_crt & (slot == SLOT_CART_HI);

	// Model is latched while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			plus4 <= model_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_ok <= 1'b0;
			cart_hi_ok <= 1'b0;
		end else begin
			if (rom_wr_o[IMG_CART_LO]) begin
				cart_lo_ok <= 1'b1;
			end
			if (rom_wr_o[IMG_CART_HI]) begin
				cart_hi_ok <= 1'b1;
			end
		end
	end

	////////////////////
	// Banking register at FDD0-FDDF, Plus/4 only

	assign cart_hold = plus4 & ld.download & is_crt;
	assign bank_wr   = plus4 & io_prev & ~cpu.cs_io_n & ~cpu.rnw
		& (cpu.addr[15:4] == BANK_REG_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_prev <= 1'b1;
		end else begin
			io_prev <= cpu.cs_io_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_hold) begin
			bank_lo <= BANK_SYS;
			bank_hi <= BANK_SYS;
		end else if (bank_wr) begin
			bank_lo <= cpu.addr[1:0];
			bank_hi <= cpu.addr[3:2];
		end
	end

	////////////////////
	// Chip-select decode

	assign kern = (cpu.addr[15:8] == KERNAL_PAGE);

	assign rom_sel_o[IMG_KERNAL]  = ~cpu.cs1_n & ((bank_hi == BANK_SYS) | kern);
	assign rom_sel_o[IMG_BASIC]   = ~cpu.cs0_n & (bank_lo == BANK_SYS);
	assign rom_sel_o[IMG_FUNC_LO] = ~cpu.cs0_n & (bank_lo == BANK_FUNC);
	assign rom_sel_o[IMG_FUNC_HI] = ~cpu.cs1_n & (bank_hi == BANK_FUNC) & ~kern;
	assign rom_sel_o[IMG_CART_LO] = ~cpu.cs0_n & cart_lo_ok & (bank_lo == BANK_CART);
	assign rom_sel_o[IMG_CART_HI] = ~cpu.cs1_n & cart_hi_ok & (bank_hi == BANK_CART) & ~kern;

	// Wired-AND read bus
	always_comb begin
		cpu_rdata_o = ram_rdata_i;
		for (int i = 0; i < NUM_IMG; i++) begin
			cpu_rdata_o = cpu_rdata_o & rom_rdata_i[i];
		end
	end

endmodule

/* c16_mem_top.sv */
`timescale 1ns/1ps

module c16_mem_top #(
	parameter int RAM_AW = 16,
	parameter int ROM_AW = 14
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    model_i,
	input  logic                    ioctl_download_i,
	input  logic                    ioctl_wr_i,
	input  logic [7:0]              ioctl_index_i,
	input  c16_load_pkg::load_addr_t ioctl_addr_i,
	input  c16_bus_pkg::cpu_data_t  ioctl_dout_i,
	input  c16_bus_pkg::cpu_addr_t  cpu_addr_i,
	input  c16_bus_pkg::cpu_data_t  cpu_wdata_i,
	input  logic                    cpu_rnw_i,
	input  logic                    cs_ram_n_i,
	input  logic                    cs0_n_i,
	input  logic                    cs1_n_i,
	input  logic                    cs_io_n_i,
	output c16_bus_pkg::cpu_data_t  cpu_rdata_o
);
	import c16_bus_pkg::*;

	cpu_addr_t            dl_addr;
	cpu_data_t            dl_data;
	logic                 dl_wr;
	cpu_data_t            ram_rdata;
	cpu_data_t            rom_rdata [NUM_IMG];
	logic [NUM_IMG-1:0]   rom_wr;
	logic [NUM_IMG-1:0]   rom_sel;
	rom_addr_t            rom_wr_addr;
	rom_addr_t            rom_rd_addr;

	load_bus_if u_load_bus ();
	cpu_bus_if  u_cpu_bus ();

	assign u_load_bus.download = ioctl_download_i;
	assign u_load_bus.index    = ioctl_index_i;
	assign u_load_bus.wr       = ioctl_wr_i;
	assign u_load_bus.addr     = ioctl_addr_i;
	assign u_load_bus.data     = ioctl_dout_i;

	assign u_cpu_bus.addr     = cpu_addr_i;
	assign u_cpu_bus.wdata    = cpu_wdata_i;
	assign u_cpu_bus.rnw      = cpu_rnw_i;
	assign u_cpu_bus.cs_ram_n = cs_ram_n_i;
	assign u_cpu_bus.cs0_n    = cs0_n_i;
	assign u_cpu_bus.cs1_n    = cs1_n_i;
	assign u_cpu_bus.cs_io_n  = cs_io_n_i;

	assign rom_wr_addr = ioctl_addr_i[13:0];
	assign rom_rd_addr = cpu_addr_i[13:0];

	prg_loader u_prg_loader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ld        (u_load_bus.sink),
		.dl_addr_o (dl_addr),
		.dl_data_o (dl_data),
		.dl_wr_o   (dl_wr)
	);

	main_ram #(.RAM_AW(RAM_AW)) u_main_ram (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (u_cpu_bus.sink),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.dl_wr_i     (dl_wr),
		.ram_rdata_o (ram_rdata)
	);

	mem_map u_mem_map (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model_i     (model_i),
		.ld          (u_load_bus.sink),
		.cpu         (u_cpu_bus.sink),
		.rom_wr_o    (rom_wr),
		.rom_sel_o   (rom_sel),
		.ram_rdata_i (ram_rdata),
		.rom_rdata_i (rom_rdata),
		.cpu_rdata_o (cpu_rdata_o)
	);

	////////////////////
	// ROM images

	rom_image #(.ROM_AW(ROM_AW)) u_kernal (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_KERNAL]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_KERNAL]),
		.rdata_o   (rom_rdata[IMG_KERNAL])
	);

	rom_image #(.ROM_AW(ROM_AW)) u_basic (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_BASIC]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_BASIC]),
		.rdata_o   (rom_rdata[IMG_BASIC])
	);

	rom_image #(.ROM_AW(ROM_AW)) u_func_lo (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_FUNC_LO]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_FUNC_LO]),
		.rdata_o   (rom_rdata[IMG_FUNC_LO])
	);

	rom_image #(.ROM_AW(ROM_AW)) u_func_hi (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_FUNC_HI]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_FUNC_HI]),
		.rdata_o   (rom_rdata[IMG_FUNC_HI])
	);

	rom_image #(.ROM_AW(ROM_AW)) u_cart_lo (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_CART_LO]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_CART_LO]),
		.rdata_o   (rom_rdata[IMG_CART_LO])
	);

	rom_image #(.ROM_AW(ROM_AW)) u_cart_hi (
		.clk_sys   (clk_sys),
		.wr_i      (rom_wr[IMG_CART_HI]),
		.wr_addr_i (rom_wr_addr),
		.wr_data_i (ioctl_dout_i),
		.rd_addr_i (rom_rd_addr),
		.sel_i     (rom_sel[IMG_CART_HI]),
		.rdata_o   (rom_rdata[IMG_CART_HI])
	);

endmodule

/* tb_c16_mem_assertions.sv */
`timescale 1ns/1ps

module tb_c16_mem_assertions (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   cs_ram_n_i,
	input logic                   cs0_n_i,
	input logic                   cs1_n_i,
	input c16_bus_pkg::cpu_data_t cpu_rdata_i
);
	import c16_bus_pkg::*;

	// Count of failed properties
	int assert_fail_cnt = 0;

	logic no_sel;

	assign no_sel = cs_ram_n_i & cs0_n_i & cs1_n_i;

	// Nothing selected leaves the wired-AND bus at its idle level
	idle_bus: assert property (@(posedge clk_sys) no_sel |=> cpu_rdata_i == BUS_IDLE)
	else begin
		$error("read bus not idle after a cycle with no chip select");
		assert_fail_cnt++;
	end

	reset_bus: assert property (@(posedge clk_sys) reset |=> cpu_rdata_i == BUS_IDLE)
	else begin
		$error("read bus not idle one cycle into reset");
		assert_fail_cnt++;
	end

endmodule

bind c16_mem_top tb_c16_mem_assertions u_assertions (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.cs_ram_n_i  (cs_ram_n_i),
	.cs0_n_i     (cs0_n_i),
	.cs1_n_i     (cs1_n_i),
	.cpu_rdata_i (cpu_rdata_o)
);

/* tb_c16_mem.sv */
`timescale 1ns/1ps

module tb_c16_mem;
	import c16_bus_pkg::*;
	import c16_load_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_RD       = 8;
	localparam int N_RAM      = 24;
	localparam int LOAD_CYC   = 35;
	localparam int RESET_CYC  = 6;
	localparam int PRG_CYC    = 1 + 66 + 2 + 18 + 64 * 3;
	localparam int PTR_CYC    = 8 * 3;
	localparam int RAM_CYC    = N_RAM * 6;
	localparam int BANK_CYC   = 4 * LOAD_CYC + 4 * (2 + N_RD * 9);
	localparam int CART_CYC   = 4 * (2 + N_RD * 9) + 2 * LOAD_CYC + RESET_CYC;
	localparam int TEST_CYC   = RESET_CYC + PRG_CYC + PTR_CYC + RAM_CYC + BANK_CYC + CART_CYC;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       model_i;
	logic       ioctl_download_i;
	logic       ioctl_wr_i;
	logic [7:0] ioctl_index_i;
	load_addr_t ioctl_addr_i;
	cpu_data_t  ioctl_dout_i;
	cpu_addr_t  cpu_addr_i;
	cpu_data_t  cpu_wdata_i;
	logic       cpu_rnw_i;
	logic       cs_ram_n_i;
	logic       cs0_n_i;
	logic       cs1_n_i;
	logic       cs_io_n_i;
	cpu_data_t  cpu_rdata_o;

	////////////////////
	// Reference model state

	logic [31:0] lfsr = 32'h59dc;
	cpu_data_t   ram_model [65536];
	cpu_data_t   img_model [NUM_IMG][16384];
	logic        m_plus4;
	bank_t       m_bank_lo;
	bank_t       m_bank_hi;
	logic        m_cart_lo;
	logic        m_cart_hi;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	c16_mem_top #(.RAM_AW(16), .ROM_AW(14)) u_c16_mem_top (.*);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	// Byte the select rules pick for a cs0 (lo_half) or cs1 read
	function automatic cpu_data_t rom_expect(input logic lo_half, input cpu_addr_t a);
		cpu_data_t r;
		rom_addr_t o;
		logic      kpage;
		r = BUS_IDLE;
		o = a[13:0];
		kpage = (a[15:8] == KERNAL_PAGE);
		if (lo_half) begin
			if (m_bank_lo == BANK_SYS) r = img_model[IMG_BASIC][o];
			else if (m_bank_lo == BANK_FUNC) r = img_model[IMG_FUNC_LO][o];
			else if (m_bank_lo == BANK_CART && m_cart_lo) r = img_model[IMG_CART_LO][o];
		end else begin
			if (m_bank_hi == BANK_SYS || kpage) r = img_model[IMG_KERNAL][o];
			else if (m_bank_hi == BANK_FUNC) r = img_model[IMG_FUNC_HI][o];
			else if (m_bank_hi == BANK_CART && m_cart_hi) r = img_model[IMG_CART_HI][o];
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_byte(input string name, input cpu_data_t exp, input cpu_data_t act);
		assert (act === exp) else begin
			$display("mismatch %s: expected %02h, actual %02h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic apply_reset(input logic m);
		@(negedge clk_sys);
		reset = 1'b1;
		model_i = m;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		m_plus4 = m;
		m_bank_lo = BANK_SYS;
		m_bank_hi = BANK_SYS;
		m_cart_lo = 1'b0;
		m_cart_hi = 1'b0;
	endtask

	// which: 0 RAM, 1 cs0, 2 cs1
	task automatic cpu_read(input string name, input int which, input cpu_addr_t a,
		input cpu_data_t exp);
		@(negedge clk_sys);
		cpu_addr_i = a;
		cpu_rnw_i = 1'b1;
		cs_ram_n_i = (which != 0);
		cs0_n_i = (which != 1);
		cs1_n_i = (which != 2);
		repeat (2) @(negedge clk_sys);
		check_byte(name, exp, cpu_rdata_o);
		cs_ram_n_i = 1'b1;
		cs0_n_i = 1'b1;
		cs1_n_i = 1'b1;
	endtask

	task automatic ram_write(input cpu_addr_t a, input cpu_data_t d);
		@(negedge clk_sys);
		cpu_addr_i = a;
		cpu_wdata_i = d;
		cpu_rnw_i = 1'b0;
		cs_ram_n_i = 1'b0;
		repeat (2) @(negedge clk_sys);
		cs_ram_n_i = 1'b1;
		cpu_rnw_i = 1'b1;
		ram_model[a] = d;
	endtask

	task automatic bank_write(input bank_t lo, input bank_t hi);
		@(negedge clk_sys);
		cpu_addr_i = {BANK_REG_PAGE, hi, lo};
		cpu_rnw_i = 1'b0;
		cs_io_n_i = 1'b0;
		@(negedge clk_sys);
		cs_io_n_i = 1'b1;
		cpu_rnw_i = 1'b1;
		if (m_plus4) begin
			m_bank_lo = lo;
			m_bank_hi = hi;
		end
	endtask

	// Fills offsets 0..15 and the kernal page offsets 3C00..3C0F
	task automatic load_image(input int img, input logic [7:0] idx, input slot_t slot);
		rom_addr_t off;
		cpu_data_t d;
		@(negedge clk_sys);
		ioctl_download_i = 1'b1;
		ioctl_index_i = idx;
		for (int k = 0; k < 32; k++) begin
			off = (k < 16) ? 14'(k) : 14'(k + 32'h3BF0);
			d = 8'(rand_bits(8));
			@(negedge clk_sys);
			ioctl_wr_i = 1'b1;
			ioctl_addr_i = {slot, off};
			ioctl_dout_i = d;
			img_model[img][off] = d;
		end
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;
		if (idx == IDX_CRT) begin
			if (img == IMG_CART_LO) m_cart_lo = 1'b1;
			if (img == IMG_CART_HI) m_cart_hi = 1'b1;
			if (m_plus4) begin
				m_bank_lo = BANK_SYS;
				m_bank_hi = BANK_SYS;
			end
		end
	endtask

	task automatic check_rom_reads(input string name);
		logic [3:0] o;
		cpu_addr_t  a;
		repeat (N_RD) begin
			o = 4'(rand_bits(4));
			a = 16'h8000 | 16'(o);
			cpu_read(name, 1, a, rom_expect(1'b1, a));
			a = 16'hC000 | 16'(o);
			cpu_read(name, 2, a, rom_expect(1'b0, a));
			a = 16'hFC00 | 16'(o);
			cpu_read(name, 2, a, rom_expect(1'b0, a));
		end
	endtask

	////////////////////
	// Tests

	task automatic prg_test();
		cpu_addr_t load_a;
		cpu_addr_t end_a;
		cpu_data_t d;
		int        n;
		load_a = 16'h1000 | 16'(rand_bits(12));
		n = 32 + int'(rand_bits(5));
		@(negedge clk_sys);
		ioctl_download_i = 1'b1;
		ioctl_index_i = IDX_PRG;
		for (int i = 0; i < n + 2; i++) begin
			if (i == 0) d = load_a[7:0];
			else if (i == 1) d = load_a[15:8];
			else begin
				d = 8'(rand_bits(8));
				ram_model[load_a + 16'(i - 2)] = d;
			end
			@(negedge clk_sys);
			ioctl_wr_i = 1'b1;
			ioctl_addr_i = 25'(i);
			ioctl_dout_i = d;
		end
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;
		// Patch takes 16 cycles after the fall, plus the RAM write latency
		repeat (18) @(negedge clk_sys);
		end_a = load_a + 16'(n);
		for (int k = 0; k < 8; k++) begin
			ram_model[PRG_PTRS[k]] = (k % 2 == 1) ? end_a[15:8] : end_a[7:0];
		end
		for (int i = 0; i < n; i++) begin
			cpu_read("prg_load", 0, load_a + 16'(i), ram_model[load_a + 16'(i)]);
		end
		for (int k = 0; k < 8; k++) begin
			cpu_read("prg_patch", 0, PRG_PTRS[k], (k % 2 == 1) ? end_a[15:8] : end_a[7:0]);
		end
	endtask

	task automatic ram_test();
		cpu_addr_t addrs[$];
		cpu_addr_t a;
		for (int i = 0; i < N_RAM; i++) begin
			a = 16'(rand_bits(16));
			ram_write(a, 8'(rand_bits(8)));
			addrs.push_back(a);
		end
		foreach (addrs[i]) begin
			cpu_read("ram_write", 0, addrs[i], ram_model[addrs[i]]);
		end
	endtask

	task automatic bank_test();
		load_image(IMG_KERNAL, IDX_ROM, SLOT_KERNAL);
		load_image(IMG_BASIC, IDX_ROM, SLOT_BASIC);
		load_image(IMG_FUNC_LO, IDX_ROM, SLOT_FUNC_LO);
		load_image(IMG_FUNC_HI, IDX_ROM, SLOT_FUNC_HI);
		for (int lo = 0; lo <= 2; lo += 2) begin
			for (int hi = 0; hi <= 2; hi += 2) begin
				bank_write(bank_t'(lo), bank_t'(hi));
				check_rom_reads("plus4_bank");
			end
		end
	endtask

	task automatic cart_test();
		bank_write(BANK_CART, BANK_CART);
		check_rom_reads("cart_absent");
		load_image(IMG_CART_LO, IDX_CRT, SLOT_CART_LO);
		load_image(IMG_CART_HI, IDX_CRT, SLOT_CART_HI);
		// Cartridge download in Plus/4 mode leaves both banks on the system ROM
		check_rom_reads("cart_hold");
		bank_write(BANK_CART, BANK_CART);
		check_rom_reads("cart_loaded");
		// C16 mode ignores the banking register
		apply_reset(1'b0);
		bank_write(BANK_CART, BANK_CART);
		check_rom_reads("c16_bank");
	endtask

	always @(negedge clk_sys) begin
		if (u_c16_mem_top.u_assertions.assert_fail_cnt != 0) begin
			$display("a concurrent assertion on the DUT ports failed");
			abort_run();
		end
	end

	initial begin
		#(TEST_CYC * 2 * CLK_PERIOD);
		$display("watchdog timeout after %0d cycles", TEST_CYC * 2);
		abort_run();
	end

	initial begin
		reset = 1'b1;
		model_i = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_addr_i = '0;
		ioctl_dout_i = 8'h00;
		cpu_addr_i = 16'h0000;
		cpu_wdata_i = 8'h00;
		cpu_rnw_i = 1'b1;
		cs_ram_n_i = 1'b1;
		cs0_n_i = 1'b1;
		cs1_n_i = 1'b1;
		cs_io_n_i = 1'b1;
		apply_reset(1'b1);
		prg_test();
		ram_test();
		bank_test();
		cart_test();
		@(negedge clk_sys);
		if (u_c16_mem_top.u_assertions.assert_fail_cnt != 0) begin
			$display("a concurrent assertion on the DUT ports failed");
			abort_run();
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* tb.f */
c16_bus_pkg.sv
c16_load_pkg.sv
cpu_bus_if.sv
load_bus_if.sv
prg_loader.sv
main_ram.sv
rom_image.sv
mem_map.sv
c16_mem_top.sv
tb_c16_mem_assertions.sv
tb_c16_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_c16_mem
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
